// File: flist.f
hdl/exec_pkg.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/stage_ex1.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/stage_ex2.sv
hdl/int_exec_core.sv
sim/tb_int_exec_core.sv

// File: hdl/div_unit.sv
module div_unit (
    input  logic               clk,
    input  logic               resetn,

    input  logic               i_valid,
    input  exec_pkg::exec_op_t i_op,
    input  exec_pkg::xlen_t    i_op_a,
    input  exec_pkg::xlen_t    i_op_b,

    output logic               o_valid,
    output exec_pkg::xlen_t    o_value
);

    logic is_signed;
    logic neg_a;
    logic neg_b;

    logic busy;
    logic [exec_pkg::DIV_CNT_W-1:0] cnt;
    exec_pkg::xlen_t divisor;
    exec_pkg::xlen_t quo;
    exec_pkg::xlen_t rem;
    logic use_rem;
    logic neg_quo;
    logic neg_rem;
    logic div_zero;

    logic [exec_pkg::XLEN:0] rem_shift;
    logic [exec_pkg::XLEN:0] diff;
    exec_pkg::xlen_t quo_fix;
    exec_pkg::xlen_t rem_fix;
    logic last_step;

    assign is_signed = i_op == exec_pkg::OP_DIV || i_op == exec_pkg::OP_REM;
    assign neg_a = is_signed && i_op_a[exec_pkg::XLEN-1];
    assign neg_b = is_signed && i_op_b[exec_pkg::XLEN-1];

    // Dividend bits shift into the partial remainder from the quotient register
    assign rem_shift = {rem, quo[exec_pkg::XLEN-1]};
    assign diff = rem_shift - {1'b0, divisor};
    assign last_step = cnt == exec_pkg::DIV_CNT_W'(exec_pkg::DIV_STEPS);

    // Magnitude math already yields the overflow result and only x/0 needs a fixup
    assign quo_fix = div_zero ? '1 : (neg_quo ? -quo : quo);
    assign rem_fix = neg_rem ? -rem : rem;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt <= '0;
            o_valid <= 1'b0;
        end
        else begin
            o_valid <= 1'b0;
            if (i_valid) begin
                busy <= 1'b1;
                cnt <= '0;
            end
            else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                    o_valid <= 1'b1;
                end
                else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            divisor <= neg_b ? -i_op_b : i_op_b;
            quo <= neg_a ? -i_op_a : i_op_a;
            rem <= '0;
            use_rem <= i_op == exec_pkg::OP_REM || i_op == exec_pkg::OP_REMU;
            neg_quo <= neg_a ^ neg_b;
            neg_rem <= neg_a;
            div_zero <= i_op_b == '0;
        end
        else if (busy && !last_step) begin
            rem <= diff[exec_pkg::XLEN] ? rem_shift[exec_pkg::XLEN-1:0]
                                        : diff[exec_pkg::XLEN-1:0];
            quo <= {quo[exec_pkg::XLEN-2:0], ~diff[exec_pkg::XLEN]};
        end
        if (busy && last_step) begin
            o_value <= use_rem ? rem_fix : quo_fix;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
        i_valid |-> !busy);

endmodule

// File: hdl/exec_pkg.sv
package exec_pkg;

    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W = $clog2(XLEN);
    localparam int DIV_STEPS = XLEN;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } exec_op_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_t;

    // Which EX2 unit produces the result of an operation
    function automatic unit_t op_unit(exec_op_t op);
        unit_t unit;
        case (op)
            OP_MUL, OP_MULH, OP_MULHU: unit = UNIT_MUL;
            OP_DIV, OP_DIVU, OP_REM, OP_REMU: unit = UNIT_DIV;
            default: unit = UNIT_ALU;
        endcase
        return unit;
    endfunction

endpackage

// File: hdl/int_exec_core.sv
module int_exec_core (
    input  logic               clk,
    input  logic               resetn,

    input  logic               i_valid,
    input  exec_pkg::exec_op_t i_op,
    input  exec_pkg::reg_idx_t i_rd,
    input  exec_pkg::reg_idx_t i_rs1,
    input  exec_pkg::reg_idx_t i_rs2,
    input  logic               i_use_imm,
    input  exec_pkg::xlen_t    i_imm,
    output logic               o_ready,

    output logic               o_wb_valid,
    output exec_pkg::reg_idx_t o_wb_rd,
    output exec_pkg::xlen_t    o_wb_data
);

    exec_pkg::xlen_t rf_rs1;
    exec_pkg::xlen_t rf_rs2;
    exec_pkg::xlen_t op_a;
    exec_pkg::xlen_t op_b;
    logic stall;
    logic accept;

    logic ex1_valid;
    exec_pkg::exec_op_t ex1_op;
    exec_pkg::reg_idx_t ex1_rd;
    exec_pkg::xlen_t ex1_op_a;
    exec_pkg::xlen_t ex1_op_b;
    exec_pkg::xlen_t ex1_value;
    logic ex1_rd_valid;
    logic ex1_value_valid;

    logic ex2_ready;
    logic ex2_rd_valid;
    exec_pkg::reg_idx_t ex2_rd;

    assign o_ready = !stall && (!ex1_valid || ex2_ready);
    assign accept = i_valid && o_ready;

    reg_file u_reg_file (
        .clk (clk), .resetn (resetn),
        .i_ra_sel (i_rs1), .i_rb_sel (i_rs2),
        .o_ra_data (rf_rs1), .o_rb_data (rf_rs2),
        .i_w_en (o_wb_valid), .i_w_sel (o_wb_rd), .i_w_data (o_wb_data)
    );

    operand_bypass u_operand_bypass (
        .i_rs1 (i_rs1), .i_rs2 (i_rs2), .i_use_imm (i_use_imm), .i_imm (i_imm),
        .i_rf_rs1 (rf_rs1), .i_rf_rs2 (rf_rs2),
        .i_ex1_rd_valid (ex1_rd_valid), .i_ex1_value_valid (ex1_value_valid),
        .i_ex1_rd (ex1_rd), .i_ex1_value (ex1_value),
        .i_ex2_rd_valid (ex2_rd_valid), .i_ex2_value_valid (o_wb_valid),
        .i_ex2_rd (ex2_rd), .i_ex2_value (o_wb_data),
        .o_op_a (op_a), .o_op_b (op_b), .o_stall (stall)
    );

    stage_ex1 u_stage_ex1 (
        .clk (clk), .resetn (resetn),
        .i_accept (accept), .i_op (i_op), .i_rd (i_rd), .i_op_a (op_a), .i_op_b (op_b),
        .i_ex2_ready (ex2_ready),
        .o_valid (ex1_valid), .o_op (ex1_op), .o_rd (ex1_rd),
        .o_op_a (ex1_op_a), .o_op_b (ex1_op_b), .o_value (ex1_value),
        .o_rd_valid (ex1_rd_valid), .o_value_valid (ex1_value_valid)
    );

    stage_ex2 u_stage_ex2 (
        .clk (clk), .resetn (resetn),
        .i_valid (ex1_valid), .i_op (ex1_op), .i_rd (ex1_rd),
        .i_op_a (ex1_op_a), .i_op_b (ex1_op_b), .i_alu_value (ex1_value),
        .o_ready (ex2_ready), .o_rd_valid (ex2_rd_valid), .o_rd (ex2_rd),
        .o_wb_valid (o_wb_valid), .o_wb_rd (o_wb_rd), .o_wb_data (o_wb_data)
    );

endmodule

// File: hdl/mul_unit.sv
module mul_unit (
    input  logic               clk,
    input  logic               resetn,

    input  logic               i_valid,
    input  exec_pkg::exec_op_t i_op,
    input  exec_pkg::xlen_t    i_op_a,
    input  exec_pkg::xlen_t    i_op_b,

    output logic               o_valid,
    output exec_pkg::xlen_t    o_value
);

    logic s1_valid;
    exec_pkg::xlen_t s1_a;
    exec_pkg::xlen_t s1_b;
    logic s1_signed;
    logic s1_high;

    logic s2_high;
    logic [2*exec_pkg::XLEN-1:0] s2_prod;

    logic signed [exec_pkg::XLEN:0] ext_a;
    logic signed [exec_pkg::XLEN:0] ext_b;
    logic signed [2*exec_pkg::XLEN+1:0] full_prod;

    // One extra bit lets a single signed multiply cover both forms
    assign ext_a = {s1_signed & s1_a[exec_pkg::XLEN-1], s1_a};
    assign ext_b = {s1_signed & s1_b[exec_pkg::XLEN-1], s1_b};
    assign full_prod = ext_a * ext_b;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            o_valid <= 1'b0;
        end
        else begin
            s1_valid <= i_valid;
            o_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a <= i_op_a;
        s1_b <= i_op_b;
        s1_signed <= i_op == exec_pkg::OP_MULH;
        s1_high <= i_op != exec_pkg::OP_MUL;
        s2_prod <= full_prod[2*exec_pkg::XLEN-1:0];
        s2_high <= s1_high;
    end

    assign o_value = s2_high ? s2_prod[2*exec_pkg::XLEN-1:exec_pkg::XLEN]
                             : s2_prod[exec_pkg::XLEN-1:0];

endmodule

// File: hdl/operand_bypass.sv
module operand_bypass (
    input  exec_pkg::reg_idx_t i_rs1,
    input  exec_pkg::reg_idx_t i_rs2,
    input  logic               i_use_imm,
    input  exec_pkg::xlen_t    i_imm,
    input  exec_pkg::xlen_t    i_rf_rs1,
    input  exec_pkg::xlen_t    i_rf_rs2,

    input  logic               i_ex1_rd_valid,
    input  logic               i_ex1_value_valid,
    input  exec_pkg::reg_idx_t i_ex1_rd,
    input  exec_pkg::xlen_t    i_ex1_value,

    input  logic               i_ex2_rd_valid,
    input  logic               i_ex2_value_valid,
    input  exec_pkg::reg_idx_t i_ex2_rd,
    input  exec_pkg::xlen_t    i_ex2_value,

    output exec_pkg::xlen_t    o_op_a,
    output exec_pkg::xlen_t    o_op_b,
    output logic               o_stall
);

    logic stall_a;
    logic stall_b;

    // EX2 checked first so that the younger EX1 result overrides it
    always_comb begin
        stall_a = 1'b0;
        o_op_a = i_rf_rs1;
        if (i_ex2_rd_valid && i_ex2_rd == i_rs1) begin
            if (i_ex2_value_valid) o_op_a = i_ex2_value;
            else stall_a = 1'b1;
        end
        if (i_ex1_rd_valid && i_ex1_rd == i_rs1) begin
            o_op_a = i_ex1_value;
            stall_a = !i_ex1_value_valid;
        end

        stall_b = 1'b0;
        o_op_b = i_rf_rs2;
        if (i_ex2_rd_valid && i_ex2_rd == i_rs2) begin
            if (i_ex2_value_valid) o_op_b = i_ex2_value;
            else stall_b = 1'b1;
        end
        if (i_ex1_rd_valid && i_ex1_rd == i_rs2) begin
            o_op_b = i_ex1_value;
            stall_b = !i_ex1_value_valid;
        end
        // Immediate replaces rs2 and removes its hazard
        if (i_use_imm) begin
            o_op_b = i_imm;
            stall_b = 1'b0;
        end
    end

    assign o_stall = stall_a || stall_b;

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic             clk,
    input  logic             resetn,

    input  exec_pkg::reg_idx_t i_ra_sel,
    input  exec_pkg::reg_idx_t i_rb_sel,
    output exec_pkg::xlen_t    o_ra_data,
    output exec_pkg::xlen_t    o_rb_data,

    input  logic               i_w_en,
    input  exec_pkg::reg_idx_t i_w_sel,
    input  exec_pkg::xlen_t    i_w_data
);

    exec_pkg::xlen_t regs [32];

    // x0 is hardwired
    assign o_ra_data = i_ra_sel == '0 ? '0 : regs[i_ra_sel];
    assign o_rb_data = i_rb_sel == '0 ? '0 : regs[i_rb_sel];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end
        else begin
            if (i_w_en && i_w_sel != '0) begin
                regs[i_w_sel] <= i_w_data;
            end
        end
    end

endmodule

// File: hdl/stage_ex1.sv
module stage_ex1 (
    input  logic                clk,
    input  logic                resetn,

    input  logic                i_accept,
    input  exec_pkg::exec_op_t  i_op,
    input  exec_pkg::reg_idx_t  i_rd,
    input  exec_pkg::xlen_t     i_op_a,
    input  exec_pkg::xlen_t     i_op_b,

    input  logic                i_ex2_ready,

    output logic                o_valid,
    output exec_pkg::exec_op_t  o_op,
    output exec_pkg::reg_idx_t  o_rd,
    output exec_pkg::xlen_t     o_op_a,
    output exec_pkg::xlen_t     o_op_b,
    output exec_pkg::xlen_t     o_value,
    output logic                o_rd_valid,
    output logic                o_value_valid
);

    exec_pkg::xlen_t alu_value;
    logic [exec_pkg::SHAMT_W-1:0] shamt;
    logic handover;

    assign shamt = i_op_b[exec_pkg::SHAMT_W-1:0];
    assign handover = o_valid && i_ex2_ready;

    always_comb begin
        case (i_op)
            exec_pkg::OP_ADD: alu_value = i_op_a + i_op_b;
            exec_pkg::OP_SUB: alu_value = i_op_a - i_op_b;
            exec_pkg::OP_AND: alu_value = i_op_a & i_op_b;
            exec_pkg::OP_OR: alu_value = i_op_a | i_op_b;
            exec_pkg::OP_XOR: alu_value = i_op_a ^ i_op_b;
            exec_pkg::OP_SLL: alu_value = i_op_a << shamt;
            exec_pkg::OP_SRL: alu_value = i_op_a >> shamt;
            exec_pkg::OP_SRA: alu_value = exec_pkg::xlen_t'($signed(i_op_a) >>> shamt);
            exec_pkg::OP_SLT: alu_value = exec_pkg::xlen_t'($signed(i_op_a) < $signed(i_op_b));
            exec_pkg::OP_SLTU: alu_value = exec_pkg::xlen_t'(i_op_a < i_op_b);
            // Non-ALU ops carry no early value
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_valid <= 1'b0;
            o_rd_valid <= 1'b0;
            o_value_valid <= 1'b0;
        end
        else begin
            if (handover) begin
                o_valid <= 1'b0;
                o_rd_valid <= 1'b0;
                o_value_valid <= 1'b0;
            end
            if (i_accept) begin
                o_valid <= 1'b1;
                o_rd_valid <= i_rd != '0;
                o_value_valid <= exec_pkg::op_unit(i_op) == exec_pkg::UNIT_ALU;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_accept) begin
            o_op <= i_op;
            o_rd <= i_rd;
            o_op_a <= i_op_a;
            o_op_b <= i_op_b;
            o_value <= alu_value;
        end
    end

    // Top level must hold off while EX1 is stuck behind EX2
    a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
        !(i_accept && o_valid && !i_ex2_ready));

endmodule

// File: hdl/stage_ex2.sv
module stage_ex2 (
    input  logic               clk,
    input  logic               resetn,

    input  logic               i_valid,
    input  exec_pkg::exec_op_t i_op,
    input  exec_pkg::reg_idx_t i_rd,
    input  exec_pkg::xlen_t    i_op_a,
    input  exec_pkg::xlen_t    i_op_b,
    input  exec_pkg::xlen_t    i_alu_value,
    output logic               o_ready,

    output logic               o_rd_valid,
    output exec_pkg::reg_idx_t o_rd,

    output logic               o_wb_valid,
    output exec_pkg::reg_idx_t o_wb_rd,
    output exec_pkg::xlen_t    o_wb_data
);

    logic busy;
    logic handover;
    exec_pkg::unit_t in_unit;
    exec_pkg::unit_t unit_sel;
    exec_pkg::reg_idx_t rd_q;

    logic alu_valid;
    exec_pkg::xlen_t alu_data;
    logic mul_valid;
    exec_pkg::xlen_t mul_data;
    logic div_valid;
    exec_pkg::xlen_t div_data;

    assign o_ready = !busy || o_wb_valid;
    assign handover = i_valid && o_ready;
    assign in_unit = exec_pkg::op_unit(i_op);

    mul_unit u_mul_unit (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (handover && in_unit == exec_pkg::UNIT_MUL),
        .i_op    (i_op),
        .i_op_a  (i_op_a),
        .i_op_b  (i_op_b),
        .o_valid (mul_valid),
        .o_value (mul_data)
    );

    div_unit u_div_unit (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (handover && in_unit == exec_pkg::UNIT_DIV),
        .i_op    (i_op),
        .i_op_a  (i_op_a),
        .i_op_b  (i_op_b),
        .o_valid (div_valid),
        .o_value (div_data)
    );

    always_comb begin
        case (unit_sel)
            exec_pkg::UNIT_MUL: begin
                o_wb_valid = mul_valid;
                o_wb_data = mul_data;
            end
            exec_pkg::UNIT_DIV: begin
                o_wb_valid = div_valid;
                o_wb_data = div_data;
            end
            default: begin
                o_wb_valid = alu_valid;
                o_wb_data = alu_data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy <= 1'b0;
            unit_sel <= exec_pkg::UNIT_ALU;
            alu_valid <= 1'b0;
            rd_q <= '0;
        end
        else if (handover) begin
            busy <= 1'b1;
            unit_sel <= in_unit;
            alu_valid <= in_unit == exec_pkg::UNIT_ALU;
            rd_q <= i_rd;
        end
        else if (o_wb_valid) begin
            busy <= 1'b0;
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (handover) alu_data <= i_alu_value;
    end

    assign o_rd_valid = busy && rd_q != '0;
    assign o_rd = rd_q;
    assign o_wb_rd = rd_q;

    // A unit result with nothing in EX2 would commit a phantom op
    a_wb_busy: assert property (@(posedge clk) disable iff (!resetn)
        o_wb_valid |-> busy);

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_int_exec_core -f flist.f

out=$(./obj_dir/Vtb_int_exec_core 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1

// File: sim/exec_golden.txt
# op rd rs1 rs2 use_imm imm expected_data, all hex
# op codes follow exec_op_t order, ADD=00 through REMU=10
00 01 00 00 1 12345678 12345678
00 02 00 00 1 80000000 80000000
00 03 00 00 1 fffffff9 fffffff9
07 04 02 00 1 00000004 f8000000
08 05 03 00 1 00000005 00000001
09 06 03 00 1 00000005 00000000
01 0a 01 03 0 00000000 1234567f
00 0b 0a 0a 0 00000000 2468acfe
02 0c 0b 0a 0 00000000 0020047e
01 0e 0b 0c 0 00000000 2448a880
0a 0f 01 03 0 00000000 8091a2b8
00 10 0f 00 1 00000008 8091a2c0
0b 11 02 03 0 00000000 00000003
0c 12 02 03 0 00000000 7ffffffc
0d 14 01 03 0 00000000 fd663ccb
0f 15 01 03 0 00000000 00000005
0e 16 01 00 0 00000000 ffffffff
10 17 03 00 0 00000000 fffffff9
0d 18 02 00 1 ffffffff 80000000
00 1a 18 15 0 00000000 80000005
00 00 01 00 1 00000001 12345679
03 1d 00 00 0 00000000 00000000

// File: sim/tb_int_exec_core.sv
module tb_int_exec_core;

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT = 200;
    localparam logic [15:0] LFSR_SEED = 16'd18404;

    logic clk;
    logic resetn;
    logic i_valid;
    exec_pkg::exec_op_t i_op;
    exec_pkg::reg_idx_t i_rd;
    exec_pkg::reg_idx_t i_rs1;
    exec_pkg::reg_idx_t i_rs2;
    logic i_use_imm;
    exec_pkg::xlen_t i_imm;
    logic o_ready;
    logic o_wb_valid;
    exec_pkg::reg_idx_t o_wb_rd;
    exec_pkg::xlen_t o_wb_data;

    logic [4:0] g_op [$];
    exec_pkg::reg_idx_t g_rd [$];
    exec_pkg::reg_idx_t g_rs1 [$];
    exec_pkg::reg_idx_t g_rs2 [$];
    logic g_use_imm [$];
    exec_pkg::xlen_t g_imm [$];
    exec_pkg::xlen_t g_data [$];
    int num_ops;

    exec_pkg::reg_idx_t exp_rd_q [$];
    exec_pkg::xlen_t exp_data_q [$];
    int commits = 0;
    logic [15:0] lfsr;

    int_exec_core u_int_exec_core (
        .clk (clk), .resetn (resetn),
        .i_valid (i_valid), .i_op (i_op), .i_rd (i_rd), .i_rs1 (i_rs1), .i_rs2 (i_rs2),
        .i_use_imm (i_use_imm), .i_imm (i_imm), .o_ready (o_ready),
        .o_wb_valid (o_wb_valid), .o_wb_rd (o_wb_rd), .o_wb_data (o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_rd(input exec_pkg::reg_idx_t got, input exec_pkg::reg_idx_t exp,
                            input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: commit %0d rd %0d, expected %0d",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_data(input exec_pkg::xlen_t got, input exec_pkg::xlen_t exp,
                              input int idx);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: commit %0d data %h, expected %h",
                                $time, idx, got, exp));
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // Ops reading one of the two previous results go back to back to exercise forwarding
    function automatic logic depends_on_recent(input int n);
        logic hit;
        hit = 1'b0;
        for (int k = n - 2; k < n; k++) begin
            if (k >= 0) begin
                if (g_rs1[n] == g_rd[k]) hit = 1'b1;
                if (!g_use_imm[n] && g_rs2[n] == g_rd[k]) hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic load_golden();
        int fd;
        int fields;
        string line;
        logic [4:0] op_code;
        exec_pkg::reg_idx_t rd;
        exec_pkg::reg_idx_t rs1;
        exec_pkg::reg_idx_t rs2;
        logic use_imm;
        exec_pkg::xlen_t imm;
        exec_pkg::xlen_t data;
        fd = $fopen("sim/exec_golden.txt", "r");
        if (fd == 0) abort_run("Could not open the golden file sim/exec_golden.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h",
                                 op_code, rd, rs1, rs2, use_imm, imm, data);
                if (fields != 7) abort_run($sformatf("Unreadable golden line: %s", line));
                g_op.push_back(op_code);
                g_rd.push_back(rd);
                g_rs1.push_back(rs1);
                g_rs2.push_back(rs2);
                g_use_imm.push_back(use_imm);
                g_imm.push_back(imm);
                g_data.push_back(data);
            end
        end
        $fclose(fd);
        num_ops = g_op.size();
    endtask

    task automatic wait_ready(input int n);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_ready) begin
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run($sformatf("Operation %0d was never accepted", n));
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (commits < num_ops) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("Not every accepted operation committed in time");
        end
    endtask

    // Commit monitor
    initial begin
        forever begin
            @(negedge clk);
            if (o_wb_valid) begin
                if (exp_rd_q.size() == 0) begin
                    abort_run("A commit appeared with no operation outstanding");
                end
                else begin
                    check_rd(o_wb_rd, exp_rd_q.pop_front(), commits);
                    check_data(o_wb_data, exp_data_q.pop_front(), commits);
                    commits++;
                end
            end
        end
    end

    initial begin
        int gap;
        resetn = 1'b0;
        i_valid = 1'b0;
        i_op = exec_pkg::OP_ADD;
        i_rd = '0;
        i_rs1 = '0;
        i_rs2 = '0;
        i_use_imm = 1'b0;
        i_imm = '0;
        lfsr = LFSR_SEED;
        load_golden();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        for (int n = 0; n < num_ops; n++) begin
            gap = 0;
            if (!depends_on_recent(n)) begin
                lfsr = lfsr_step(lfsr);
                gap = lfsr[0] ? 2 : 0;
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) gap = gap + 1;
            end
            repeat (gap) begin
                @(posedge clk);
                i_valid <= 1'b0;
            end
            @(posedge clk);
            i_valid <= 1'b1;
            i_op <= exec_pkg::exec_op_t'(g_op[n]);
            i_rd <= g_rd[n];
            i_rs1 <= g_rs1[n];
            i_rs2 <= g_rs2[n];
            i_use_imm <= g_use_imm[n];
            i_imm <= g_imm[n];
            wait_ready(n);
            // Transfer happens at the coming rising edge
            exp_rd_q.push_back(g_rd[n]);
            exp_data_q.push_back(g_data[n]);
        end
        @(posedge clk);
        i_valid <= 1'b0;

        wait_drain();
        $display("Simulation passed");
        $finish;
    end

endmodule
